/* files.f */
axi_wr_pkg.sv
axi_burst_planner.sv
axi_wdata_aligner.sv
axi_wr_bridge.sv
tb_axi_mem_model.sv
tb_axi_wr.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -f files.f --top-module tb_axi_wr -o tb_axi_wr
	./obj_dir/tb_axi_wr | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_axi_wr.sv */
`default_nettype none

module tb_axi_wr;
   timeunit 1ns;
   timeprecision 100ps;

   logic clk_i = 1'b0;
   logic rst_i = 1'b1;
   logic m_wvalid_i = 1'b0;
   axi_wr_pkg::axi_addr_t m_waddr_i = '0;
   axi_wr_pkg::axi_data_t m_wdata_i = '0;
   axi_wr_pkg::byte_len_t m_wlen_i = '0;
   logic m_wready_o, m_wlast_o, m_werr_o;
   axi_wr_pkg::axi_aw_t aw_o;
   axi_wr_pkg::axi_w_t w_o;
   axi_wr_pkg::axi_b_t b_i;
   logic awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i;

   logic mem_clear = 1'b0;
   logic [7:0] err_burst = 8'hff;
   logic [1:0] ready_mask = 2'b11;
   logic stall_on = 1'b0;
   int proto_errs;

   logic [31:0] lfsr = 32'h348b2114;
   logic [7:0] ref_bytes [0:263];
   logic [31:0] rnd_addr [0:29];
   int rnd_len [0:29];
   int errors = 0, tests = 0, errs_at_start = 0, xfer_no = 0, budget = 0;
   string test_name = "reset";

   // Monitor state for the running transfer
   logic [31:0] xfer_start, xfer_end, next_addr, w_addr;
   int xfer_len, aw_cnt, beat_cnt, mlast_cnt, ready_cnt, w_beat, w_len;

   axi_wr_bridge dut0 (.*);

   tb_axi_mem_model mem0 (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(mem_clear), .err_burst_i(err_burst),
      .ready_mask_i(ready_mask), .aw_i(aw_o), .awvalid_i(awvalid_o), .awready_o(awready_i),
      .w_i(w_o), .wvalid_i(wvalid_o), .wready_o(wready_i), .b_o(b_i), .bvalid_o(bvalid_i),
      .proto_errs_o(proto_errs)
   );

   always #4 clk_i = ~clk_i;

   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [7:0] fill_byte(input logic [11:0] a);
      return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
   endfunction

   function automatic axi_wr_pkg::axi_data_t client_word(input int k);
      return {ref_bytes[4*k+3], ref_bytes[4*k+2], ref_bytes[4*k+1], ref_bytes[4*k]};
   endfunction

   task automatic fail(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
   endtask

   task automatic note_error(input string what);
      $display("%s: %s", test_name, what);
      errors++;
   endtask

   always @(posedge clk_i) ready_mask <= stall_on ? 2'(rand_bits(2)) : 2'b11;

   always @(posedge clk_i) begin : monitor
      logic [31:0] bend, line_end, exp_end, ba;
      axi_wr_pkg::axi_strb_t exp_strb;
      if (awvalid_o && awready_i) begin
         bend     = aw_o.addr + (32'(aw_o.len) + 32'd1) * 32'd4;
         line_end = (aw_o.addr | 32'd63) + 32'd1;
         exp_end  = (line_end < xfer_end) ? line_end : xfer_end;
         assert (aw_o.addr == next_addr) else fail("burst address", next_addr, aw_o.addr);
         assert (bend == exp_end) else fail("burst end", exp_end, bend);
         next_addr = bend;
         w_addr    = aw_o.addr;
         w_beat    = 0;
         w_len     = int'(aw_o.len);
         aw_cnt++;
      end
      if (wvalid_o && wready_i) begin
         for (int i = 0; i < 4; i++) begin
            ba = w_addr + 32'(i);
            exp_strb[i] = (ba >= xfer_start) && (ba < xfer_start + 32'(xfer_len));
         end
         assert (w_o.strb == exp_strb) else fail("strobe", 32'(exp_strb), 32'(w_o.strb));
         assert (w_o.last == (w_beat == w_len)) else fail("wlast", 32'(w_beat == w_len),
                                                            32'(w_o.last));
         w_addr += 32'd4;
         w_beat++;
         beat_cnt++;
      end
      if (m_wready_o) ready_cnt++;
      if (m_wlast_o) mlast_cnt++;
   end

   aw_delay_a: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(m_wvalid_i) |-> ##2 awvalid_o)
      else note_error("AW not issued 2 cycles after request");
   w_follows_aw_a: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_o && awready_i |=> wvalid_o)
      else note_error("W did not follow the AW handshake");
   mlast_on_w_a: assert property (@(posedge clk_i) disable iff (rst_i)
      m_wlast_o |-> wvalid_o && wready_i && w_o.last)
      else note_error("m_wlast_o without last beat");
   werr_sticky_a: assert property (@(posedge clk_i) disable iff (rst_i)
      m_werr_o |=> m_werr_o) else note_error("error flag dropped");

   task automatic run_transfer(input logic [31:0] addr, input int len, input logic [7:0] eb,
                               input logic exp_err);
      int idx, n_beats, n_bursts;
      logic [31:0] a;
      logic [7:0] exp;
      xfer_no++;
      for (int i = 0; i < 264; i++) ref_bytes[i] = 8'(xfer_no * 37 + i * 11 + 3);
      @(posedge clk_i);
      mem_clear <= 1'b1;
      err_burst <= eb;
      @(posedge clk_i);
      mem_clear <= 1'b0;
      xfer_start = addr;
      xfer_len   = len;
      xfer_end   = ((addr + 32'(len) - 32'd1) | 32'd3) + 32'd1;
      next_addr  = addr & ~32'd3;
      aw_cnt = 0;
      beat_cnt = 0;
      mlast_cnt = 0;
      ready_cnt = 0;
      @(posedge clk_i);
      m_waddr_i  <= addr;
      m_wlen_i   <= 8'(len);
      m_wvalid_i <= 1'b1;
      m_wdata_i  <= client_word(0);
      idx = 0;
      do begin
         @(posedge clk_i);
         if (m_wready_o) begin
            idx++;
            m_wdata_i <= client_word(idx);
         end
      end while (!m_wlast_o);
      m_wvalid_i <= 1'b0;
      do @(posedge clk_i); while (!bvalid_i);
      @(posedge clk_i);
      n_beats  = (int'(addr[1:0]) + len + 3) / 4;
      n_bursts = int'(((xfer_end - 32'd1) >> 6) - (addr >> 6)) + 1;
      assert (beat_cnt == n_beats) else fail("beat count", n_beats, beat_cnt);
      assert (aw_cnt == n_bursts) else fail("burst count", n_bursts, aw_cnt);
      assert (ready_cnt == (len + 3) / 4) else fail("client word count", (len + 3) / 4,
                                                    ready_cnt);
      assert (mlast_cnt == 1) else fail("m_wlast_o count", 1, mlast_cnt);
      assert (m_werr_o == exp_err) else fail("m_werr_o", 32'(exp_err), 32'(m_werr_o));
      for (a = addr - 32'd4; a < addr + 32'(len) + 32'd4; a++) begin
         exp = (a >= addr && a < addr + 32'(len)) ? ref_bytes[a - addr] : fill_byte(a[11:0]);
         assert (mem0.mem[a[11:0]] == exp) else fail($sformatf("byte %0h", a), 32'(exp),
                                                       32'(mem0.mem[a[11:0]]));
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errs_at_start = errors + proto_errs;
   endtask

   task automatic end_test;
      int n;
      n = errors + proto_errs - errs_at_start;
      tests++;
      if (n == 0) $display("test %s: passed", test_name);
      else $display("test %s: %0d check(s) failed", test_name, n);
   endtask

   initial begin
      for (int i = 0; i < 30; i++) begin
         rnd_addr[i] = 32'h100 + rand_bits(10);
         rnd_len[i]  = int'(rand_bits(8));
         if (rnd_len[i] == 0) rnd_len[i] = 1;
      end
      budget = 4 + 64 + 135 + 255 + 200 + 20 + 10;
      for (int i = 0; i < 30; i++) budget += rnd_len[i];
      budget *= 40;
      repeat (10) @(posedge clk_i);
      rst_i <= 1'b0;

      begin_test("aligned");
      run_transfer(32'h100, 4, 8'hff, 1'b0);
      run_transfer(32'h140, 64, 8'hff, 1'b0);
      end_test();
      begin_test("unaligned");
      for (int off = 1; off < 4; off++)
         for (int len = 1; len < 10; len++) run_transfer(32'h200 + 32'(off), len, 8'hff, 1'b0);
      end_test();
      begin_test("long_255");
      run_transfer(32'h301, 255, 8'hff, 1'b0);
      end_test();
      begin_test("random_stall");
      stall_on <= 1'b1;
      for (int i = 0; i < 30; i++) run_transfer(rnd_addr[i], rnd_len[i], 8'hff, 1'b0);
      @(posedge clk_i);
      stall_on <= 1'b0;
      end_test();
      begin_test("error_resp");
      assert (m_werr_o == 1'b0) else fail("m_werr_o before error", 0, 32'(m_werr_o));
      run_transfer(32'h400, 200, 8'd2, 1'b1);
      run_transfer(32'h500, 20, 8'hff, 1'b1);  // Flag must survive a clean transfer
      end_test();

      $display("%0d tests, %0d failed checks", tests, errors + proto_errs);
      if (errors + proto_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      wait (budget > 0);
      #(budget * 8);
      $display("Timeout after %0d cycles, the tests did not finish", budget);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_axi_mem_model.sv */
`default_nettype none

module tb_axi_mem_model (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  clear_i,        // Refill memory, restart burst numbering
   input  logic [7:0]            err_burst_i,    // Burst number answered with SLVERR
   input  logic [1:0]            ready_mask_i,   // {wready, awready}
   input  axi_wr_pkg::axi_aw_t   aw_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  axi_wr_pkg::axi_w_t    w_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   output axi_wr_pkg::axi_b_t    b_o,
   output logic                  bvalid_o,
   output int                    proto_errs_o
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0]            mem [0:4095];
   logic                  have_aw;
   axi_wr_pkg::axi_addr_t wad;                 // Address of the next beat
   logic [7:0]            beat;
   axi_wr_pkg::beat_len_t len;
   logic [7:0]            burst_no;
   int                    proto_errs = 0;

   function automatic logic [7:0] fill_byte(input logic [11:0] a);
      return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
   endfunction

   assign awready_o    = ready_mask_i[0];
   assign wready_o     = ready_mask_i[1];
   assign proto_errs_o = proto_errs;

   always_ff @(posedge clk_i) begin
      if (clear_i) begin
         for (int i = 0; i < 4096; i++) mem[i] <= fill_byte(12'(i));
      end else if (wvalid_i && wready_o) begin
         for (int i = 0; i < 4; i++) begin
            if (w_i.strb[i]) mem[12'(wad + 32'(i))] <= w_i.data[8*i +: 8];
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         have_aw  <= 1'b0;
         wad      <= '0;
         beat     <= '0;
         len      <= '0;
         burst_no <= '0;
         bvalid_o <= 1'b0;
         b_o      <= '0;
      end else begin
         bvalid_o <= 1'b0;
         if (clear_i) burst_no <= '0;
         if (awvalid_i && awready_o) begin
            have_aw <= 1'b1;
            wad     <= aw_i.addr;
            beat    <= '0;
            len     <= aw_i.len;
         end
         if (wvalid_i && wready_o) begin
            wad  <= wad + 32'd4;
            beat <= beat + 8'd1;
            if (w_i.last) begin
               have_aw  <= 1'b0;
               bvalid_o <= 1'b1;
               b_o.resp <= (burst_no == err_burst_i) ? 2'b10 : 2'b00;
               burst_no <= burst_no + 8'd1;
            end
         end
      end
   end

   w_after_aw_a: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i |-> have_aw)
      else begin
         proto_errs++;
         $display("W beat arrived before its AW handshake");
      end

   aw_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_i && !awready_o |=> awvalid_i && $stable(aw_i))
      else begin
         proto_errs++;
         $display("AW channel changed while stalled");
      end

   w_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_o |=> wvalid_i && $stable(w_i))
      else begin
         proto_errs++;
         $display("W channel changed while stalled");
      end

   wlast_at_len_a: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && wready_o |-> w_i.last == (beat == len))
      else begin
         proto_errs++;
         $display("wlast does not match the burst length");
      end

endmodule

`default_nettype wire

/* axi_wr_bridge.sv */
`default_nettype none

module axi_wr_bridge (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  m_wvalid_i,
   input  axi_wr_pkg::axi_addr_t m_waddr_i,
   input  axi_wr_pkg::axi_data_t m_wdata_i,
   input  axi_wr_pkg::byte_len_t m_wlen_i,
   output logic                  m_wready_o,
   output logic                  m_wlast_o,
   output logic                  m_werr_o,
   output axi_wr_pkg::axi_aw_t   aw_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output axi_wr_pkg::axi_w_t    w_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   input  axi_wr_pkg::axi_b_t    b_i,
   input  logic                  bvalid_i
);

   axi_wr_pkg::wr_state_e state_q;
   axi_wr_pkg::axi_aw_t   aw_q;                  // Burst being issued
   logic                  last_burst_q;
   axi_wr_pkg::byte_off_t offset_q;
   logic [8:0]            words_q;               // Client words in the transfer
   logic [3:0]            beat_q;                // Beat index inside the burst
   logic [8:0]            xfer_q;                // Beat index inside the transfer
   logic                  wvalid_q;
   logic                  werr_q;

   logic                  start;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  burst_end;
   logic                  first_beat;
   logic                  last_beat;
   logic                  flush_beat;
   axi_wr_pkg::axi_strb_t wstrb;

   axi_wr_pkg::axi_aw_t   burst;
   logic [8:0]            total_beats;
   axi_wr_pkg::axi_strb_t first_strb;
   axi_wr_pkg::axi_strb_t last_strb;
   logic                  last_burst;
   axi_wr_pkg::axi_data_t wdata;

   assign start = (state_q == axi_wr_pkg::idle) && m_wvalid_i;
   assign aw_hs = awvalid_o && awready_i;
   assign w_hs  = wvalid_q && wready_i;

   axi_burst_planner planner0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .addr_i       (m_waddr_i),
      .len_i        (m_wlen_i),
      .start_i      (start),
      .next_i       (aw_hs),
      .burst_o      (burst),
      .total_beats_o(total_beats),
      .first_strb_o (first_strb),
      .last_strb_o  (last_strb),
      .last_burst_o (last_burst)
   );

   axi_wdata_aligner aligner0 (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .offset_i(offset_q),
      .data_i  (m_wdata_i),
      .shift_i (w_hs),
      .data_o  (wdata)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q      <= axi_wr_pkg::idle;
         last_burst_q <= 1'b0;
         offset_q     <= '0;
         words_q      <= '0;
         beat_q       <= '0;
         xfer_q       <= '0;
         wvalid_q     <= 1'b0;
      end else begin
         case (state_q)
            axi_wr_pkg::idle: begin
               if (m_wvalid_i) begin
                  offset_q <= m_waddr_i[axi_wr_pkg::off_w-1:0];
                  words_q  <= (9'(m_wlen_i) + 9'd3) >> axi_wr_pkg::off_w;
                  xfer_q   <= '0;
                  state_q  <= axi_wr_pkg::load;
               end
            end
            axi_wr_pkg::load: begin  // Planner output settled here
               last_burst_q <= last_burst;
               beat_q       <= '0;
               state_q      <= axi_wr_pkg::addr;
            end
            axi_wr_pkg::addr: begin
               if (awready_i) begin
                  wvalid_q <= 1'b1;
                  state_q  <= axi_wr_pkg::data;
               end
            end
            axi_wr_pkg::data: begin
               if (w_hs) begin
                  beat_q <= beat_q + 4'd1;
                  xfer_q <= xfer_q + 9'd1;
                  if (burst_end) begin
                     wvalid_q <= 1'b0;
                     state_q  <= last_burst_q ? axi_wr_pkg::idle : axi_wr_pkg::load;
                  end
               end
            end
            default: state_q <= axi_wr_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == axi_wr_pkg::load) begin
         aw_q <= burst;
      end
   end

   // Sticky error on any non-OKAY response
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         werr_q <= 1'b0;
      end else if (bvalid_i && (b_i.resp != axi_wr_pkg::resp_okay)) begin
         werr_q <= 1'b1;
      end
   end

   assign burst_end  = ({4'b0000, beat_q} == aw_q.len);
   assign first_beat = (xfer_q == 9'd0);
   assign last_beat  = (xfer_q == total_beats - 9'd1);

   // Extra beat that only drains the held word, no client word behind it
   assign flush_beat = last_beat && (total_beats > words_q);

   always_comb begin
      wstrb = '1;
      if (first_beat) begin
         wstrb = first_strb;
      end
      if (last_beat) begin
         wstrb = wstrb & last_strb;  // Single-beat transfer gets both
      end
   end

   assign aw_o      = aw_q;
   assign awvalid_o = (state_q == axi_wr_pkg::addr);

   assign w_o.data = wdata;
   assign w_o.strb = wstrb;
   assign w_o.last = burst_end;
   assign wvalid_o = wvalid_q;

   assign m_wready_o = w_hs && !flush_beat;
   assign m_wlast_o  = w_hs && burst_end && last_burst_q;
   assign m_werr_o   = werr_q;

   aw_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
      else $error("AW changed while stalled");

   w_in_data_a: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_o |-> state_q == axi_wr_pkg::data)
      else $error("wvalid outside the data state");

   // Planner burst split and bridge beat count must agree on the end
   one_wlast_a: assert property (@(posedge clk_i) disable iff (rst_i)
      m_wlast_o |-> (xfer_q == total_beats - 9'd1) ##1 !m_wlast_o)
      else $error("m_wlast_o not on the final transfer beat");

endmodule

`default_nettype wire

/* axi_wdata_aligner.sv */
`default_nettype none

module axi_wdata_aligner (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axi_wr_pkg::byte_off_t offset_i,
   input  axi_wr_pkg::axi_data_t data_i,
   input  logic                  shift_i,
   output axi_wr_pkg::axi_data_t data_o
);

   axi_wr_pkg::axi_data_t       held_q;         // Previous client word
   logic [2*axi_wr_pkg::data_w-1:0] pair;
   logic [2*axi_wr_pkg::data_w-1:0] shifted;
   logic [5:0]                  shamt;

   // Lanes under the offset come from the held word, the rest from the new one
   assign pair    = {data_i, held_q};
   assign shamt   = {3'(axi_wr_pkg::strb_w) - 3'(offset_i), 3'b000};
   assign shifted = pair >> shamt;
   assign data_o  = shifted[axi_wr_pkg::data_w-1:0];

   // Accepted word feeds the low lanes of the next beat
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         held_q <= '0;
      end else if (shift_i) begin
         held_q <= data_i;
      end
   end

endmodule

`default_nettype wire

/* axi_burst_planner.sv */
`default_nettype none

module axi_burst_planner (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axi_wr_pkg::axi_addr_t addr_i,
   input  axi_wr_pkg::byte_len_t len_i,
   input  logic                  start_i,
   input  logic                  next_i,
   output axi_wr_pkg::axi_aw_t   burst_o,
   output logic [8:0]            total_beats_o,
   output axi_wr_pkg::axi_strb_t first_strb_o,
   output axi_wr_pkg::axi_strb_t last_strb_o,
   output logic                  last_burst_o
);

   axi_wr_pkg::axi_addr_t cur_addr_q;
   logic [8:0]            rem_q;                  // Beats not yet issued on AW
   logic [8:0]            total_q;
   axi_wr_pkg::axi_strb_t first_strb_q;
   axi_wr_pkg::axi_strb_t last_strb_q;

   axi_wr_pkg::byte_off_t start_off;
   logic [8:0]            span;
   logic [8:0]            total_beats;
   logic [8:0]            to_bound;
   logic [8:0]            n_beats;
   axi_wr_pkg::axi_addr_t burst_end_addr;

   assign start_off = addr_i[axi_wr_pkg::off_w-1:0];

   // Distance from aligned start to last byte
   assign span        = 9'(start_off) + 9'(len_i) - 9'd1;
   assign total_beats = (span >> axi_wr_pkg::off_w) + 9'd1;

   // Beats left before the next 64-byte line
   assign to_bound = 9'(axi_wr_pkg::max_beats) - 9'(cur_addr_q[5:2]);
   assign n_beats  = (rem_q < to_bound) ? rem_q : to_bound;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr_q <= '0;
         rem_q      <= '0;
         total_q    <= '0;
      end else if (start_i) begin
         cur_addr_q <= {addr_i[axi_wr_pkg::addr_w-1:axi_wr_pkg::off_w],
                        {axi_wr_pkg::off_w{1'b0}}};
         rem_q      <= total_beats;
         total_q    <= total_beats;
      end else if (next_i) begin
         cur_addr_q <= cur_addr_q + axi_wr_pkg::axi_addr_t'({n_beats, 2'b00});
         rem_q      <= rem_q - n_beats;
      end
   end

   // Edge strobes of the whole transfer
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         first_strb_q <= {axi_wr_pkg::strb_w{1'b1}} << start_off;
         last_strb_q  <= {axi_wr_pkg::strb_w{1'b1}} >> (2'd3 - span[1:0]);
      end
   end

   assign burst_o.addr  = cur_addr_q;
   assign burst_o.len   = axi_wr_pkg::beat_len_t'(n_beats - 9'd1);
   assign total_beats_o = total_q;
   assign first_strb_o  = first_strb_q;
   assign last_strb_o   = last_strb_q;
   assign last_burst_o  = (rem_q <= to_bound);  // Rest fits before the boundary

   // Address of the last byte covered by the issued burst
   assign burst_end_addr = burst_o.addr
                           + axi_wr_pkg::axi_addr_t'({burst_o.len, 2'b11});

   burst_in_line_a: assert property (@(posedge clk_i) disable iff (rst_i)
      next_i |-> (burst_o.addr[axi_wr_pkg::addr_w-1:6]
                  == burst_end_addr[axi_wr_pkg::addr_w-1:6]))
      else $error("burst at %h crosses a 64-byte boundary", burst_o.addr);

endmodule

`default_nettype wire

/* axi_wr_pkg.sv */
`default_nettype none

package axi_wr_pkg;

   localparam int addr_w    = 32;
   localparam int data_w    = 32;
   localparam int len_w     = 8;
   localparam int strb_w    = data_w / 8;
   localparam int off_w     = 2;                   // Byte offset inside a word
   localparam int max_beats = 16;                  // 64 bytes per burst at most

   localparam logic [1:0] resp_okay = 2'b00;

   typedef logic [addr_w-1:0] axi_addr_t;
   typedef logic [data_w-1:0] axi_data_t;
   typedef logic [strb_w-1:0] axi_strb_t;
   typedef logic [len_w-1:0]  byte_len_t;          // Transfer length in bytes
   typedef logic [len_w-1:0]  beat_len_t;          // AXI awlen, beats minus one
   typedef logic [off_w-1:0]  byte_off_t;

   // One burst request on AW
   typedef struct packed {
      axi_addr_t addr;
      beat_len_t len;
   } axi_aw_t;

   // One write beat on W
   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

   // Bridge sequencing, one pass of load/addr/data per burst
   typedef enum logic [1:0] {
      idle,
      load,
      addr,
      data
   } wr_state_e;

endpackage

`default_nettype wire
